//--- src/dmem_macros.svh
/*
 Sizes of the scratch-pad data memory
 Bank count must equal 2**DMEM_BANK_SEL_W, bank depth is 2**DMEM_WORD_AW words
 Burst length is held in DMEM_WORD_AW+1 bits, so one burst covers at most one bank
*/
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// Word width in bits
`define DMEM_DATA_W 32

// Word-address bits inside one bank (64 words)
`define DMEM_WORD_AW 6

// Banks and bank-select bits
`define DMEM_NUM_BANKS 2
`define DMEM_BANK_SEL_W 1

// Client lanes per direction
`define DMEM_NUM_LANES 2

`endif

//--- src/dmem_pkg.sv
/*
 Shared types of the scratch-pad data memory
 A global address is the bank-select field above an in-bank word address
 Length counts words, 1 up to one full bank; zero is not a legal length
*/
`include "dmem_macros.svh"

package dmem_pkg;

	typedef logic [`DMEM_DATA_W-1:0]		data_t;			// One memory word
	typedef logic [`DMEM_WORD_AW-1:0]		word_addr_t;	// Address inside a bank
	typedef logic [`DMEM_BANK_SEL_W-1:0]	bank_sel_t;		// Bank-select field
	typedef logic [`DMEM_WORD_AW:0]			length_t;		// Burst word count, 1..64

	typedef struct packed {
		bank_sel_t	bank;		// Upper bits pick the bank
		word_addr_t	word;		// Word inside that bank
	} addr_t;

	typedef struct packed {
		word_addr_t	base;		// First word
		word_addr_t	stride;		// Step between words, wraps in bank
		length_t	length;		// Words in the burst
	} access_desc_t;

	typedef struct packed {
		logic			req;	// One-cycle request pulse
		bank_sel_t		bank;	// Target bank
		access_desc_t	desc;
	} lane_req_t;

	typedef logic [`DMEM_NUM_LANES-1:0]	lane_onehot_t;	// One bit per lane

endpackage

//--- src/req_arbiter.sv
/*
 Pending latch and fixed-priority grant for one bank and one direction
 A lane may hold only one request per direction until it sees done
 Lowest lane index wins when several are pending in an idle cycle
*/
`include "dmem_macros.svh"

module req_arbiter
	import dmem_pkg::*;
(
	input						clock,
	input						reset,
	input	lane_req_t			req [`DMEM_NUM_LANES],
	input	logic				done,			// Last word of the running burst
	output	lane_onehot_t		grant,
	output	access_desc_t		desc,			// Descriptor of the granted lane
	output	logic				start			// First cycle of a grant
);

	lane_onehot_t				pending_q;
	lane_onehot_t				pend;
	lane_onehot_t				pick;
	access_desc_t				desc_q [`DMEM_NUM_LANES];
	access_desc_t				pend_desc [`DMEM_NUM_LANES];
	int unsigned				sel;

	////////////////////////////////////////////////////////////
	// Merge new pulses with latched requests, pick lowest lane
	////////////////////////////////////////////////////////////
	always_comb begin
		pend	= pending_q;
		sel		= 0;
		pick	= '0;
		for ( int l = `DMEM_NUM_LANES-1; l >= 0; l-- ) begin
			pend_desc[l]	= req[l].req ? req[l].desc : desc_q[l];
			if ( req[l].req ) begin
				pend[l]	= 1'b1;
			end
			if ( pend[l] ) begin
				sel		= l;		// Ends on the lowest pending lane
			end
		end
		if ( ( grant == '0 ) && ( pend != '0 ) ) begin
			pick[sel]	= 1'b1;
		end
	end

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			pending_q	<= '0;
			grant		<= '0;
			start		<= 1'b0;
		end
		else begin
			pending_q	<= pend & ~pick;
			start		<= |pick;
			if ( |pick ) begin
				grant	<= pick;
			end
			else if ( done ) begin
				grant	<= '0;	// Falls the cycle after the last word
			end
		end
	end

	always_ff @( posedge clock ) begin
		for ( int l = 0; l < `DMEM_NUM_LANES; l++ ) begin
			if ( req[l].req ) begin
				desc_q[l]	<= req[l].desc;
			end
		end
		if ( |pick ) begin
			desc	<= pend_desc[sel];	// Held for the whole grant
		end
	end

endmodule

//--- src/agu.sv
/*
 Strided address generator for one burst
 desc must stay stable from start until the last word
 Address wraps inside the bank; a step under stall does not count
*/
module agu
	import dmem_pkg::*;
(
	input						clock,
	input						reset,
	input						stall,
	input						start,			// Load base and length
	input						step,			// Lane has a word ready
	input	access_desc_t		desc,
	output	word_addr_t			addr,
	output	logic				fire,			// Word moves this cycle
	output	logic				last			// Final word of the burst
);

	word_addr_t					addr_q;
	length_t					count_q;
	length_t					count;
	logic						busy;

	// Start cycle works straight from the descriptor
	assign addr		= start ? desc.base : addr_q;
	assign count	= start ? desc.length : count_q;
	assign fire		= ( start | busy ) & step & ~stall;
	assign last		= fire & ( count == length_t'(1) );

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			busy	<= 1'b0;
			count_q	<= '0;
		end
		else begin
			if ( last ) begin
				busy	<= 1'b0;
			end
			else if ( start ) begin
				busy	<= 1'b1;
			end
			if ( fire ) begin
				count_q	<= count - 1'b1;
			end
			else if ( start ) begin
				count_q	<= desc.length;
			end
		end
	end

	always_ff @( posedge clock ) begin
		if ( fire ) begin
			addr_q	<= addr + desc.stride;	// Natural wrap at bank size
		end
		else if ( start ) begin
			addr_q	<= desc.base;
		end
	end

endmodule

//--- src/dmem_bank.sv
/*
 One bank of the scratch-pad memory with its store and load engines
 Store and load bursts run independently; a read and a write to the same
 word in one cycle returns the old word
 Load data appears one cycle after the word is fired
*/
`include "dmem_macros.svh"

module dmem_bank
	import dmem_pkg::*;
(
	input						clock,
	input						reset,
	input						stall,
	input	lane_req_t			st_req [`DMEM_NUM_LANES],
	input	lane_req_t			ld_req [`DMEM_NUM_LANES],
	input	lane_onehot_t		st_valid,
	input	lane_onehot_t		ld_valid,
	input	data_t				st_data [`DMEM_NUM_LANES],
	output	lane_onehot_t		st_grant,
	output	lane_onehot_t		ld_grant,
	output	logic				st_done,
	output	logic				ld_done,
	output	data_t				ld_data,
	output	logic				ld_data_valid
);

	access_desc_t				st_desc;
	access_desc_t				ld_desc;
	logic						st_start;
	logic						ld_start;
	logic						st_step;
	logic						ld_step;
	logic						st_fire;
	logic						ld_fire;
	word_addr_t					st_addr;
	word_addr_t					ld_addr;
	data_t						wr_data;
	data_t						mem [2**`DMEM_WORD_AW];

	assign st_step	= |( st_valid & st_grant );	// Valid of the granted lane
	assign ld_step	= |( ld_valid & ld_grant );

	// Store data of the granted lane
	always_comb begin
		wr_data	= '0;
		for ( int l = 0; l < `DMEM_NUM_LANES; l++ ) begin
			if ( st_grant[l] ) begin
				wr_data	= st_data[l];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Word array
	////////////////////////////////////////////////////////////
	always_ff @( posedge clock ) begin
		if ( st_fire ) begin
			mem[st_addr]	<= wr_data;
		end
		if ( ld_fire ) begin
			ld_data			<= mem[ld_addr];
		end
	end

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			ld_data_valid	<= 1'b0;
		end
		else begin
			ld_data_valid	<= ld_fire;
		end
	end

	req_arbiter arb_st (
		.clock( clock ), .reset( reset ), .req( st_req ), .done( st_done ),
		.grant( st_grant ), .desc( st_desc ), .start( st_start )
	);

	req_arbiter arb_ld (
		.clock( clock ), .reset( reset ), .req( ld_req ), .done( ld_done ),
		.grant( ld_grant ), .desc( ld_desc ), .start( ld_start )
	);

	agu agu_st (
		.clock( clock ), .reset( reset ), .stall( stall ), .start( st_start ),
		.step( st_step ), .desc( st_desc ), .addr( st_addr ), .fire( st_fire ),
		.last( st_done )
	);

	agu agu_ld (
		.clock( clock ), .reset( reset ), .stall( stall ), .start( ld_start ),
		.step( ld_step ), .desc( ld_desc ), .addr( ld_addr ), .fire( ld_fire ),
		.last( ld_done )
	);

endmodule

//--- src/req_dispatch.sv
/*
 Steers each lane request to the bank named by its global base
 The global base of a request is {bank, desc.base}
 Purely combinational; descriptors pass through unchanged
*/
`include "dmem_macros.svh"

module req_dispatch
	import dmem_pkg::*;
(
	input	lane_req_t			st_req_in [`DMEM_NUM_LANES],
	input	lane_req_t			ld_req_in [`DMEM_NUM_LANES],
	output	lane_req_t			st_req_bank [`DMEM_NUM_BANKS][`DMEM_NUM_LANES],
	output	lane_req_t			ld_req_bank [`DMEM_NUM_BANKS][`DMEM_NUM_LANES]
);

	// Copy of a request as seen by bank b
	function automatic lane_req_t steer( lane_req_t r, int unsigned b );
		lane_req_t	o;
		o		= r;
		o.req	= r.req & ( r.bank == bank_sel_t'(b) );
		return o;
	endfunction

	always_comb begin
		for ( int b = 0; b < `DMEM_NUM_BANKS; b++ ) begin
			for ( int l = 0; l < `DMEM_NUM_LANES; l++ ) begin
				st_req_bank[b][l]	= steer( st_req_in[l], b );
				ld_req_bank[b][l]	= steer( ld_req_in[l], b );
			end
		end
	end

endmodule

//--- src/load_merge.sv
/*
 Returns grants, done pulses and load data from the banks to the lanes
 A lane is served by at most one bank per direction at a time
 Load data follows the load grant of the previous cycle
*/
`include "dmem_macros.svh"

module load_merge
	import dmem_pkg::*;
(
	input						clock,
	input						reset,
	input	lane_onehot_t		st_grant_bank [`DMEM_NUM_BANKS],
	input	lane_onehot_t		ld_grant_bank [`DMEM_NUM_BANKS],
	input	logic [`DMEM_NUM_BANKS-1:0]	st_done_bank,
	input	logic [`DMEM_NUM_BANKS-1:0]	ld_done_bank,
	input	logic [`DMEM_NUM_BANKS-1:0]	ld_data_valid_bank,
	input	data_t				ld_data_bank [`DMEM_NUM_BANKS],
	output	lane_onehot_t		st_grant,
	output	lane_onehot_t		ld_grant,
	output	lane_onehot_t		st_done,
	output	lane_onehot_t		ld_done,
	output	lane_onehot_t		ld_data_valid,
	output	data_t				ld_data [`DMEM_NUM_LANES]
);

	lane_onehot_t				ld_grant_q [`DMEM_NUM_BANKS];	// Aligned with read data

	always_ff @( posedge clock ) begin
		for ( int b = 0; b < `DMEM_NUM_BANKS; b++ ) begin
			ld_grant_q[b]	<= reset ? '0 : ld_grant_bank[b];
		end
	end

	always_comb begin
		st_grant		= '0;
		ld_grant		= '0;
		st_done			= '0;
		ld_done			= '0;
		ld_data_valid	= '0;
		for ( int l = 0; l < `DMEM_NUM_LANES; l++ ) begin
			ld_data[l]	= '0;
		end
		for ( int b = 0; b < `DMEM_NUM_BANKS; b++ ) begin
			st_grant		|= st_grant_bank[b];
			ld_grant		|= ld_grant_bank[b];
			st_done			|= st_grant_bank[b] & {`DMEM_NUM_LANES{st_done_bank[b]}};
			ld_done			|= ld_grant_bank[b] & {`DMEM_NUM_LANES{ld_done_bank[b]}};
			ld_data_valid	|= ld_grant_q[b] & {`DMEM_NUM_LANES{ld_data_valid_bank[b]}};
			for ( int l = 0; l < `DMEM_NUM_LANES; l++ ) begin
				if ( ld_grant_q[b][l] & ld_data_valid_bank[b] ) begin
					ld_data[l]	= ld_data_bank[b];
				end
			end
		end
	end

endmodule

//--- src/dmem_top.sv
/*
 Multi-bank scratch-pad data memory with two client lanes
 Request base is global: bank field in req.bank, word in req.desc.base
 One outstanding burst per lane and direction; stall freezes all banks
*/
`include "dmem_macros.svh"

module dmem_top
	import dmem_pkg::*;
(
	input						clock,
	input						reset,
	input						stall,
	input	lane_req_t			st_req [`DMEM_NUM_LANES],
	input	lane_req_t			ld_req [`DMEM_NUM_LANES],
	input	lane_onehot_t		st_valid,
	input	lane_onehot_t		ld_valid,
	input	data_t				st_data [`DMEM_NUM_LANES],
	output	lane_onehot_t		st_grant,
	output	lane_onehot_t		ld_grant,
	output	lane_onehot_t		st_done,
	output	lane_onehot_t		ld_done,
	output	lane_onehot_t		ld_data_valid,
	output	data_t				ld_data [`DMEM_NUM_LANES]
);

	lane_req_t					st_req_bank [`DMEM_NUM_BANKS][`DMEM_NUM_LANES];
	lane_req_t					ld_req_bank [`DMEM_NUM_BANKS][`DMEM_NUM_LANES];
	lane_onehot_t				st_grant_bank [`DMEM_NUM_BANKS];
	lane_onehot_t				ld_grant_bank [`DMEM_NUM_BANKS];
	lane_onehot_t				st_valid_bank [`DMEM_NUM_BANKS];
	lane_onehot_t				ld_valid_bank [`DMEM_NUM_BANKS];
	logic [`DMEM_NUM_BANKS-1:0]	st_done_bank;
	logic [`DMEM_NUM_BANKS-1:0]	ld_done_bank;
	logic [`DMEM_NUM_BANKS-1:0]	ld_data_valid_bank;
	data_t						ld_data_bank [`DMEM_NUM_BANKS];

	req_dispatch req_dispatch (
		.st_req_in( st_req ), .ld_req_in( ld_req ),
		.st_req_bank( st_req_bank ), .ld_req_bank( ld_req_bank )
	);

	for ( genvar b = 0; b < `DMEM_NUM_BANKS; b++ ) begin : g_bank
		assign st_valid_bank[b]	= st_valid & st_grant_bank[b];	// Only lanes this bank serves
		assign ld_valid_bank[b]	= ld_valid & ld_grant_bank[b];

		dmem_bank dmem_bank (
			.clock( clock ), .reset( reset ), .stall( stall ),
			.st_req( st_req_bank[b] ), .ld_req( ld_req_bank[b] ),
			.st_valid( st_valid_bank[b] ), .ld_valid( ld_valid_bank[b] ),
			.st_data( st_data ),
			.st_grant( st_grant_bank[b] ), .ld_grant( ld_grant_bank[b] ),
			.st_done( st_done_bank[b] ), .ld_done( ld_done_bank[b] ),
			.ld_data( ld_data_bank[b] ), .ld_data_valid( ld_data_valid_bank[b] )
		);
	end

	load_merge load_merge (
		.clock( clock ), .reset( reset ),
		.st_grant_bank( st_grant_bank ), .ld_grant_bank( ld_grant_bank ),
		.st_done_bank( st_done_bank ), .ld_done_bank( ld_done_bank ),
		.ld_data_valid_bank( ld_data_valid_bank ), .ld_data_bank( ld_data_bank ),
		.st_grant( st_grant ), .ld_grant( ld_grant ),
		.st_done( st_done ), .ld_done( ld_done ),
		.ld_data_valid( ld_data_valid ), .ld_data( ld_data )
	);

endmodule

//--- bench/dmem_properties.sv
/*
 Bound checks on the request and grant rules of the data memory
 A lane may not request a direction again before its done pulse
 Grants of one bank are at most one-hot
*/
`include "dmem_macros.svh"

module dmem_properties
	import dmem_pkg::*;
(
	input					clock,
	input					reset,
	input	lane_req_t		st_req [`DMEM_NUM_LANES],
	input	lane_req_t		ld_req [`DMEM_NUM_LANES],
	input	lane_onehot_t	st_done,
	input	lane_onehot_t	ld_done,
	input	lane_onehot_t	st_grant_bank [`DMEM_NUM_BANKS],
	input	lane_onehot_t	ld_grant_bank [`DMEM_NUM_BANKS]
);

	timeunit 1ns;
	timeprecision 1ps;

	lane_onehot_t			st_busy;		// Request seen, done not yet
	lane_onehot_t			ld_busy;

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			st_busy	<= '0;
			ld_busy	<= '0;
		end
		else begin
			for ( int l = 0; l < `DMEM_NUM_LANES; l++ ) begin
				if ( st_done[l] ) begin
					st_busy[l]	<= 1'b0;
				end
				else if ( st_req[l].req ) begin
					st_busy[l]	<= 1'b1;
				end
				if ( ld_done[l] ) begin
					ld_busy[l]	<= 1'b0;
				end
				else if ( ld_req[l].req ) begin
					ld_busy[l]	<= 1'b1;
				end
			end
		end
	end

	for ( genvar l = 0; l < `DMEM_NUM_LANES; l++ ) begin : g_lane
		a_st_one_burst : assert property ( @( posedge clock ) disable iff ( reset )
			st_req[l].req |-> !st_busy[l] )
			else $error( "Store request on lane %0d while its burst runs", l );
		a_ld_one_burst : assert property ( @( posedge clock ) disable iff ( reset )
			ld_req[l].req |-> !ld_busy[l] )
			else $error( "Load request on lane %0d while its burst runs", l );
		a_st_length : assert property ( @( posedge clock ) disable iff ( reset )
			st_req[l].req |-> ( st_req[l].desc.length != '0 ) )
			else $error( "Store request on lane %0d with zero length", l );
		a_ld_length : assert property ( @( posedge clock ) disable iff ( reset )
			ld_req[l].req |-> ( ld_req[l].desc.length != '0 ) )
			else $error( "Load request on lane %0d with zero length", l );
	end

	for ( genvar b = 0; b < `DMEM_NUM_BANKS; b++ ) begin : g_bank
		a_grant_onehot : assert property ( @( posedge clock ) disable iff ( reset )
			$onehot0( st_grant_bank[b] ) && $onehot0( ld_grant_bank[b] ) )
			else $error( "Bank %0d grants more than one lane", b );
	end

endmodule

bind dmem_top dmem_properties props (
	.clock( clock ), .reset( reset ), .st_req( st_req ), .ld_req( ld_req ),
	.st_done( st_done ), .ld_done( ld_done ),
	.st_grant_bank( st_grant_bank ), .ld_grant_bank( ld_grant_bank )
);

//--- bench/dmem_tb.sv
/*
 Testbench for the multi-bank scratch-pad memory
 Rows flagged with_next start in the same cycle and must use different lanes
 Loads read only words that earlier rows stored
 Hold mask per row: bits 7:0 drop valid, bits 15:8 raise stall, cycle mod 8
*/
`include "dmem_macros.svh"

module dmem_tb
	import dmem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int			LANES		= `DMEM_NUM_LANES;
	localparam int			NUM_ROWS	= 17;
	localparam int			BURST_LIMIT	= 200;			// Cycles per group of rows
	localparam logic [31:0]	SEED		= 32'h496c_21dd;

	typedef enum logic [1:0] {IDLE, WAIT, BUSY, TAIL} phase_t;

	typedef struct packed {
		logic			lane;
		logic			load;			// 0 store, 1 load
		addr_t			base;			// Global base, bank above word
		word_addr_t		stride;
		length_t		length;
		logic [15:0]	hold;
		logic			with_next;		// Next row starts in the same cycle
	} row_t;

	row_t rows [NUM_ROWS] = '{
		// lane  load  base   stride length hold      next
		{1'b0, 1'b0, 7'h05, 6'd1, 7'd8,  16'h0000, 1'b0},	// Store then load back
		{1'b0, 1'b1, 7'h05, 6'd1, 7'd8,  16'h0000, 1'b0},
		{1'b1, 1'b0, 7'h78, 6'd1, 7'd24, 16'h0000, 1'b0},	// Fill bank 1 around the wrap
		{1'b1, 1'b0, 7'h7C, 6'd3, 7'd6,  16'h0000, 1'b0},	// Stride 3 past word 63
		{1'b1, 1'b1, 7'h78, 6'd1, 7'd24, 16'h0000, 1'b0},
		{1'b0, 1'b0, 7'h10, 6'd2, 7'd10, 16'h0000, 1'b1},	// Two banks at once
		{1'b1, 1'b0, 7'h50, 6'd1, 7'd12, 16'h0000, 1'b0},
		{1'b0, 1'b1, 7'h10, 6'd2, 7'd10, 16'h0000, 1'b1},
		{1'b1, 1'b1, 7'h50, 6'd1, 7'd12, 16'h0000, 1'b0},
		{1'b0, 1'b0, 7'h28, 6'd1, 7'd6,  16'h0000, 1'b1},	// Same bank, lane 0 first
		{1'b1, 1'b0, 7'h30, 6'd1, 7'd5,  16'h0000, 1'b0},
		{1'b1, 1'b1, 7'h30, 6'd1, 7'd5,  16'h0000, 1'b1},
		{1'b0, 1'b1, 7'h28, 6'd1, 7'd6,  16'h0000, 1'b0},
		{1'b1, 1'b0, 7'h01, 6'd5, 7'd9,  16'h2C93, 1'b0},	// Valid drops and stalls
		{1'b0, 1'b0, 7'h60, 6'd1, 7'd7,  16'h4124, 1'b1},
		{1'b1, 1'b1, 7'h01, 6'd5, 7'd9,  16'h0C91, 1'b0},
		{1'b0, 1'b1, 7'h60, 6'd1, 7'd7,  16'h8306, 1'b0}
	};

	logic				clock;
	logic				reset;
	logic				stall;
	lane_req_t			st_req [LANES];
	lane_req_t			ld_req [LANES];
	lane_onehot_t		st_valid;
	lane_onehot_t		ld_valid;
	data_t				st_data [LANES];
	lane_onehot_t		st_grant;
	lane_onehot_t		ld_grant;
	lane_onehot_t		st_done;
	lane_onehot_t		ld_done;
	lane_onehot_t		ld_data_valid;
	data_t				ld_data [LANES];

	data_t				model [2**(`DMEM_BANK_SEL_W+`DMEM_WORD_AW)];	// Expected contents
	logic [31:0]		lcg_state;
	int					done_seen;
	phase_t				phase [LANES];
	row_t				cur [LANES];		// Burst each lane is running
	addr_t				addr [LANES];		// Next expected address
	length_t			left [LANES];		// Words still to move
	int					age [LANES];		// Cycles since the request
	int					free_w [LANES];		// Unblocked cycles without grant
	int					blocker [LANES];	// Lower lane holding the same bank
	data_t				next_word [LANES];
	logic				exp_ldv [LANES];
	data_t				exp_ldd [LANES];

	dmem_top dut0 (
		.clock( clock ), .reset( reset ), .stall( stall ),
		.st_req( st_req ), .ld_req( ld_req ), .st_valid( st_valid ), .ld_valid( ld_valid ),
		.st_data( st_data ), .st_grant( st_grant ), .ld_grant( ld_grant ),
		.st_done( st_done ), .ld_done( ld_done ),
		.ld_data_valid( ld_data_valid ), .ld_data( ld_data )
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	function automatic logic [31:0] lcg_next( input logic [31:0] s );
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic any_active();
		logic	act;
		act	= 1'b0;
		for ( int l = 0; l < LANES; l++ ) begin
			act	|= ( phase[l] != IDLE );
		end
		return act;
	endfunction

	task automatic stop_on_error( input string line );
		$display( "%s", line );
		$display( ">>> FAIL" );
		$fatal( 1, "Stopped at the first error" );
	endtask

	task automatic value_error( input string msg );
		stop_on_error( $sformatf( "FAIL at %0t ns: %s", $time, msg ) );
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus, driven right after the rising edge
	////////////////////////////////////////////////////////////
	task automatic launch( input int r );
		lane_req_t	q;
		int			l;
		l				= rows[r].lane;
		q				= '0;
		q.req			= 1'b1;
		q.bank			= rows[r].base.bank;
		q.desc.base		= rows[r].base.word;
		q.desc.stride	= rows[r].stride;
		q.desc.length	= rows[r].length;
		if ( rows[r].load ) begin
			ld_req[l]	<= q;
		end
		else begin
			st_req[l]	<= q;
		end
		cur[l]		= rows[r];
		addr[l]		= rows[r].base;
		left[l]		= rows[r].length;
		age[l]		= 0;
		free_w[l]	= 0;
		blocker[l]	= -1;
		phase[l]	= WAIT;
		if ( !rows[r].load ) begin
			lcg_state		= lcg_next( lcg_state );
			next_word[l]	= lcg_state;	// First store word
		end
	endtask

	task automatic mark_blocked();
		for ( int l = 0; l < LANES; l++ ) begin
			for ( int j = 0; j < l; j++ ) begin
				if ( phase[j] == WAIT && phase[l] == WAIT && cur[j].load == cur[l].load
					&& cur[j].base.bank == cur[l].base.bank ) begin
					blocker[l]	= j;	// Lower lane wins the bank
				end
			end
		end
	endtask

	task automatic drive_cycle();
		lane_onehot_t	sv;
		lane_onehot_t	lv;
		logic			hold_stall;
		int				k;
		sv			= '0;
		lv			= '0;
		hold_stall	= 1'b0;
		for ( int l = 0; l < LANES; l++ ) begin
			k	= age[l] % 8;
			if ( phase[l] != IDLE ) begin
				if ( cur[l].load ) begin
					lv[l]	= ~cur[l].hold[k];
				end
				else begin
					sv[l]	= ~cur[l].hold[k];
				end
				hold_stall	|= cur[l].hold[8 + k];
			end
			st_req[l].req	<= 1'b0;
			ld_req[l].req	<= 1'b0;
			st_data[l]		<= next_word[l];
		end
		st_valid	<= sv;
		ld_valid	<= lv;
		stall		<= hold_stall;
	endtask

	////////////////////////////////////////////////////////////
	// Checks at the falling edge
	////////////////////////////////////////////////////////////
	task automatic sample_cycle();
		lane_onehot_t	was_active;
		logic			g;
		logic			d;
		logic			other;
		logic			fire;
		for ( int l = 0; l < LANES; l++ ) begin
			was_active[l]	= ( phase[l] != IDLE );
		end
		for ( int l = 0; l < LANES; l++ ) begin
			assert ( ld_data_valid[l] === exp_ldv[l] )
				else value_error( $sformatf( "lane %0d ld_data_valid is %b", l, ld_data_valid[l] ) );
			if ( exp_ldv[l] ) begin
				assert ( ld_data[l] === exp_ldd[l] )
					else value_error( $sformatf( "lane %0d ld_data %h, expected %h",
						l, ld_data[l], exp_ldd[l] ) );
			end
			exp_ldv[l]	= 1'b0;
			g		= cur[l].load ? ld_grant[l] : st_grant[l];
			d		= cur[l].load ? ld_done[l] : st_done[l];
			other	= cur[l].load ? ( st_grant[l] | st_done[l] ) : ( ld_grant[l] | ld_done[l] );
			if ( d === 1'b1 ) begin
				done_seen++;
			end
			if ( phase[l] == IDLE || phase[l] == TAIL ) begin
				assert ( !( g | d | other ) )
					else value_error( $sformatf( "lane %0d grant or done high without burst", l ) );
				phase[l]	= IDLE;		// Grant fell the cycle after done
			end
			else begin
				assert ( !other ) else value_error( $sformatf( "lane %0d wrong direction active", l ) );
				if ( phase[l] == WAIT ) begin
					assert ( g || !d ) else value_error( $sformatf( "lane %0d done before grant", l ) );
					if ( blocker[l] >= 0 && was_active[blocker[l]] ) begin
						assert ( !g ) else value_error( $sformatf( "lane %0d granted on busy bank", l ) );
						free_w[l]	= 1;		// Pending already, grant due once the bank frees
					end
					else if ( g ) begin
						assert ( !( blocker[l] < 0 && free_w[l] == 0 ) )
							else value_error( $sformatf( "lane %0d granted in request cycle", l ) );
						phase[l]	= BUSY;
					end
					else begin
						free_w[l]++;
						assert ( free_w[l] < 2 )
							else stop_on_error( $sformatf( "Timeout: lane %0d never got its grant", l ) );
					end
				end
				if ( phase[l] == BUSY ) begin
					fire	= ( cur[l].load ? ld_valid[l] : st_valid[l] ) & ~stall;
					assert ( g ) else value_error( $sformatf( "lane %0d grant fell before done", l ) );
					assert ( d === ( fire && left[l] == 1 ) )
						else value_error( $sformatf( "lane %0d done is %b with %0d words left",
							l, d, left[l] ) );
					if ( fire ) begin
						if ( cur[l].load ) begin
							exp_ldv[l]	= 1'b1;
							exp_ldd[l]	= model[addr[l]];
						end
						else begin
							model[addr[l]]	= next_word[l];
							lcg_state		= lcg_next( lcg_state );
							next_word[l]	= lcg_state;
						end
						addr[l].word	= addr[l].word + cur[l].stride;	// Wraps inside the bank
						left[l]			= left[l] - 1'b1;
						if ( left[l] == 0 ) begin
							phase[l]	= TAIL;
						end
					end
				end
			end
			age[l]++;
		end
	endtask

	task automatic run_cycle();
		@( posedge clock );
		drive_cycle();
		@( negedge clock );
		sample_cycle();
	endtask

	initial begin
		int		r;
		int		cycles;
		reset		= 1'b1;
		stall		= 1'b0;
		st_valid	= '0;
		ld_valid	= '0;
		lcg_state	= SEED;
		done_seen	= 0;
		for ( int l = 0; l < LANES; l++ ) begin
			st_req[l]		= '0;
			ld_req[l]		= '0;
			st_data[l]		= '0;
			next_word[l]	= '0;
			cur[l]			= '0;
			addr[l]			= '0;
			left[l]			= '0;
			phase[l]		= IDLE;
			age[l]			= 0;
			free_w[l]		= 0;
			blocker[l]		= -1;
			exp_ldv[l]		= 1'b0;
			exp_ldd[l]		= '0;
		end
		repeat ( 8 ) @( posedge clock );
		reset	<= 1'b0;
		// Outputs stay quiet until the first request
		for ( int i = 0; i < 4; i++ ) begin
			run_cycle();
		end
		r	= 0;
		while ( r < NUM_ROWS ) begin
			@( posedge clock );
			drive_cycle();
			launch( r );
			r++;
			while ( rows[r-1].with_next && r < NUM_ROWS ) begin
				launch( r );
				r++;
			end
			mark_blocked();
			@( negedge clock );
			sample_cycle();
			cycles	= 0;
			while ( any_active() ) begin
				assert ( cycles < BURST_LIMIT )
					else stop_on_error( "Timeout: a burst group did not finish" );
				run_cycle();
				cycles++;
			end
		end
		if ( done_seen == NUM_ROWS ) begin
			$display( ">>> PASS" );
			$finish;
		end
		else begin
			value_error( $sformatf( "%0d done pulses, expected %0d", done_seen, NUM_ROWS ) );
		end
	end

endmodule

//--- vlog.f
+incdir+src
src/dmem_pkg.sv
src/req_arbiter.sv
src/agu.sv
src/dmem_bank.sv
src/req_dispatch.sv
src/load_merge.sv
src/dmem_top.sv
bench/dmem_properties.sv
bench/dmem_tb.sv

//--- Bender.yml
package:
  name: dmem

sources:
  - include_dirs:
      - src
    files:
      - src/dmem_pkg.sv
      - src/req_arbiter.sv
      - src/agu.sv
      - src/dmem_bank.sv
      - src/req_dispatch.sv
      - src/load_merge.sv
      - src/dmem_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/dmem_properties.sv
      - bench/dmem_tb.sv
